/* build.f */
sys_pkg.sv
sys_bus_if.sv
sram_port.sv
uart_port.sv
bus_decode.sv
mem_io_system.sv
sram_model.sv
tb_mem_io_system.sv

/* Bender.yml */
package:
  name: mem_io_system

sources:
  - target: rtl
    files:
      - sys_pkg.sv
      - sys_bus_if.sv
      - sram_port.sv
      - uart_port.sv
      - bus_decode.sv
      - mem_io_system.sv
  - target: test
    files:
      - sram_model.sv
      - tb_mem_io_system.sv

/* tb_mem_io_system.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_io_system
   import sys_pkg::*;
();

   localparam int    CLK_HZ      = 1_000_000;
   localparam int    BAUD        = 100_000;
   localparam int    ACK_TIMEOUT = 20;
   localparam int    POLL_LIMIT  = 100;
   localparam addr_t DATA_REG    = 20'h0FE08;
   localparam addr_t STAT_REG    = 20'h0FE09;

   logic       clk;
   logic       rst_n;
   logic       cyc;
   logic       stb;
   logic       we;
   addr_t      adr;
   data_t      dat_w;
   data_t      dat_r;
   logic       ack;
   logic       ram_cs_n;
   logic       ram_oe_n;
   logic       ram_we_n;
   sram_addr_t ram_adr;
   wire data_t ram_dat;
   // txd looped back to rxd
   wire        serial;

   integer seed;
   int     pass_count;
   int     fail_count;
   int     test_start_fails;
   int     sram_strobes = 0;
   string  test_name;

   mem_io_system #(
      .CLK_HZ (CLK_HZ),
      .BAUD   (BAUD)
   ) dut_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .cyc      (cyc),
      .stb      (stb),
      .we       (we),
      .adr      (adr),
      .dat_w    (dat_w),
      .dat_r    (dat_r),
      .ack      (ack),
      .ram_cs_n (ram_cs_n),
      .ram_oe_n (ram_oe_n),
      .ram_we_n (ram_we_n),
      .ram_adr  (ram_adr),
      .ram_dat  (ram_dat),
      .rxd      (serial),
      .txd      (serial)
   );

   sram_model model_i (
      .ram_cs_n (ram_cs_n),
      .ram_oe_n (ram_oe_n),
      .ram_we_n (ram_we_n),
      .ram_adr  (ram_adr),
      .ram_dat  (ram_dat)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Counts SRAM write pulses to prove a cycle missed the SRAM
   always @(negedge ram_we_n)
   begin
      sram_strobes = sram_strobes + 1;
   end

   task automatic check_data(input string what, input data_t exp, input data_t act);
      if (act !== exp)
      begin
         $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic check_byte(input string what, input uart_byte_t exp, input uart_byte_t act);
      if (act !== exp)
      begin
         $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic check_addr(input string what, input sram_addr_t exp, input sram_addr_t act);
      if (act !== exp)
      begin
         $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("FAILED %s: %s expected %b actual %b", test_name, what, exp, act);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      if (act != exp)
      begin
         $display("FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   // One Wishbone classic cycle entered and left 1 ns after a rising edge
   task automatic bus_cycle(input logic write, input addr_t a, input data_t wdata,
                            output data_t rdata, output int lat);
      logic got;
      got   = 1'b0;
      lat   = 0;
      rdata = 'x;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = a;
      dat_w = wdata;
      while (!got && lat < ACK_TIMEOUT)
      begin
         @(posedge clk);
         #1;
         lat++;
         got = (ack === 1'b1);
      end
      if (got)
      begin
         rdata = dat_r;
      end
      else
      begin
         $display("ERROR %s: no ack within %0d cycles at address %h", test_name,
                  ACK_TIMEOUT, a);
         fail_count++;
      end
      // Transfer completes on the edge that sees ack
      @(posedge clk);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic wb_write(input addr_t a, input data_t d, output int lat);
      data_t unused;
      bus_cycle(1'b1, a, d, unused, lat);
   endtask

   task automatic wb_read(input addr_t a, output data_t d, output int lat);
      bus_cycle(1'b0, a, '0, d, lat);
   endtask

   task automatic wait_status(input int bit_pos, input logic want, input string what);
      data_t status;
      int    lat;
      int    polls;
      polls = 0;
      wb_read(STAT_REG, status, lat);
      while (status[bit_pos] !== want && polls < POLL_LIMIT)
      begin
         wb_read(STAT_REG, status, lat);
         polls++;
      end
      if (status[bit_pos] !== want)
      begin
         $display("ERROR %s: gave up waiting for %s after %0d status reads", test_name,
                  what, POLL_LIMIT);
         fail_count++;
      end
   endtask

   task automatic start_test(input string name);
      test_name        = name;
      test_start_fails = fail_count;
   endtask

   task automatic end_test();
      $display("%s finished with %0d errors", test_name, fail_count - test_start_fails);
   endtask

   task automatic reset_values();
      data_t status;
      int    lat;
      start_test("reset_state");
      check_flag("txd", 1'b1, serial);
      check_flag("ram_cs_n", 1'b0, ram_cs_n);
      check_flag("ram_oe_n", 1'b1, ram_oe_n);
      check_flag("ram_we_n", 1'b1, ram_we_n);
      check_flag("ack", 1'b0, ack);
      check_data("ram_dat released", 'z, ram_dat);
      wb_read(STAT_REG, status, lat);
      check_data("status", 16'h0000, status);
      end_test();
   endtask

   task automatic sram_write_read();
      sram_addr_t addrs [16];
      data_t      values [16];
      data_t      rd;
      int         lat;
      start_test("sram_rw");
      for (int i = 0; i < 16; i++)
      begin
         // Low nibble is the index so no two addresses collide
         addrs[i] = sram_addr_t'($random(seed));
         addrs[i][3:0] = i[3:0];
         if (addrs[i][15:0] == UART_DATA_ADR || addrs[i][15:0] == UART_STAT_ADR)
         begin
            addrs[i][15] = 1'b0;
         end
         values[i] = data_t'($random(seed));
      end
      addrs[0]  = '0;
      addrs[15] = '1;
      for (int i = 0; i < 16; i++)
      begin
         wb_write({2'b00, addrs[i]}, values[i], lat);
         check_count("write ack cycles", 2, lat);
         check_addr("ram_adr after write", addrs[i], ram_adr);
      end
      for (int i = 0; i < 16; i++)
      begin
         wb_read({2'b00, addrs[i]}, rd, lat);
         check_data($sformatf("word %h", addrs[i]), values[i], rd);
         check_count("read ack cycles", 2, lat);
      end
      end_test();
   endtask

   task automatic address_decode();
      data_t      word;
      data_t      rd;
      uart_byte_t b;
      int         lat;
      int         strobes;
      start_test("decode");
      word = data_t'($random(seed));
      b    = uart_byte_t'($random(seed));
      wb_write(20'h1FE0A, word, lat);
      strobes = sram_strobes;
      wb_write(20'h5FE08, {8'h00, b}, lat);
      check_count("UART ack cycles", 1, lat);
      check_count("SRAM write strobes", strobes, sram_strobes);
      wb_read(20'h3FE09, rd, lat);
      check_flag("tx_busy", 1'b1, rd[STAT_TX_BUSY_BIT]);
      wait_status(STAT_RX_VALID_BIT, 1'b1, "rx_valid");
      wb_read(DATA_REG, rd, lat);
      check_byte("looped byte", b, rd[7:0]);
      wb_read(20'h1FE0A, rd, lat);
      check_data("word at FE0A", word, rd);
      wait_status(STAT_TX_BUSY_BIT, 1'b0, "transmitter idle");
      end_test();
   endtask

   task automatic uart_loopback();
      data_t      rd;
      uart_byte_t b;
      int         lat;
      start_test("loopback");
      b = uart_byte_t'($random(seed));
      wb_write(DATA_REG, {8'h00, b}, lat);
      wb_read(STAT_REG, rd, lat);
      check_flag("tx_busy", 1'b1, rd[STAT_TX_BUSY_BIT]);
      wait_status(STAT_RX_VALID_BIT, 1'b1, "rx_valid");
      wb_read(DATA_REG, rd, lat);
      check_byte("received byte", b, rd[7:0]);
      wb_read(STAT_REG, rd, lat);
      check_flag("rx_valid after read", 1'b0, rd[STAT_RX_VALID_BIT]);
      wait_status(STAT_TX_BUSY_BIT, 1'b0, "transmitter idle");
      end_test();
   endtask

   task automatic busy_discard();
      data_t      rd;
      uart_byte_t b1;
      logic       seen;
      int         lat;
      start_test("busy_discard");
      b1   = uart_byte_t'($random(seed));
      seen = 1'b0;
      wb_write(DATA_REG, {8'h00, b1}, lat);
      // Lands while the first byte is on the line
      wb_write(DATA_REG, {8'h00, ~b1}, lat);
      wait_status(STAT_RX_VALID_BIT, 1'b1, "rx_valid");
      wb_read(DATA_REG, rd, lat);
      check_byte("first byte", b1, rd[7:0]);
      wait_status(STAT_TX_BUSY_BIT, 1'b0, "transmitter idle");
      // Watch longer than one frame for a second byte
      for (int i = 0; i < 60; i++)
      begin
         wb_read(STAT_REG, rd, lat);
         seen = seen | rd[STAT_RX_VALID_BIT];
      end
      check_flag("second byte received", 1'b0, seen);
      end_test();
   endtask

   task automatic uart_ack_latency();
      data_t      rd;
      uart_byte_t b;
      int         lat;
      start_test("uart_latency");
      wb_read(STAT_REG, rd, lat);
      check_count("status read ack cycles", 1, lat);
      check_data("status", 16'h0000, rd);
      wb_write(STAT_REG, 16'hFFFF, lat);
      check_count("status write ack cycles", 1, lat);
      wb_read(STAT_REG, rd, lat);
      check_data("status after status write", 16'h0000, rd);
      wb_read(DATA_REG, rd, lat);
      check_count("data read ack cycles", 1, lat);
      b = uart_byte_t'($random(seed));
      wb_write(DATA_REG, {8'h00, b}, lat);
      check_count("data write ack cycles", 1, lat);
      wait_status(STAT_RX_VALID_BIT, 1'b1, "rx_valid");
      wb_read(DATA_REG, rd, lat);
      check_byte("received byte", b, rd[7:0]);
      wait_status(STAT_TX_BUSY_BIT, 1'b0, "transmitter idle");
      end_test();
   endtask

   initial
   begin
      seed       = 40961;
      pass_count = 0;
      fail_count = 0;
      rst_n      = 1'b0;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat_w      = '0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      reset_values();
      sram_write_read();
      address_decode();
      uart_loopback();
      busy_discard();
      uart_ack_latency();
      $display("checks passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sram_model.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_model
   import sys_pkg::*;
(
   input  logic       ram_cs_n,
   input  logic       ram_oe_n,
   input  logic       ram_we_n,
   input  sram_addr_t ram_adr,
   inout  wire data_t ram_dat
);

   // 256K words, undefined at power-up
   data_t mem [0:(1 << $bits(sram_addr_t)) - 1];
   logic  reading;

   assign reading = (ram_cs_n === 1'b0) && (ram_oe_n === 1'b0) && (ram_we_n === 1'b1);

   // Output follows the address while oe_n is low
   assign ram_dat = reading ? mem[ram_adr] : 'z;

   // Data present at the rising edge of we_n is stored
   always @(posedge ram_we_n)
   begin
      if (ram_cs_n === 1'b0 && !$isunknown(ram_adr))
      begin
         mem[ram_adr] <= ram_dat;
      end
   end

endmodule

`default_nettype wire

/* mem_io_system.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_io_system
   import sys_pkg::*;
#(
   parameter int CLK_HZ = 50_000_000,
   parameter int BAUD   = 115_200
)
(
   input  logic       clk,
   input  logic       rst_n,
   // Wishbone classic slave
   input  logic       cyc,
   input  logic       stb,
   input  logic       we,
   input  addr_t      adr,
   input  data_t      dat_w,
   output data_t      dat_r,
   output logic       ack,
   // External asynchronous SRAM
   output logic       ram_cs_n,
   output logic       ram_oe_n,
   output logic       ram_we_n,
   output sram_addr_t ram_adr,
   inout  wire data_t ram_dat,
   // Serial lines
   input  logic       rxd,
   output logic       txd
);

   sys_bus_if sram_bus ();
   sys_bus_if uart_bus ();

   bus_decode decode_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .cyc      (cyc),
      .stb      (stb),
      .we       (we),
      .adr      (adr),
      .dat_w    (dat_w),
      .dat_r    (dat_r),
      .ack      (ack),
      .sram_bus (sram_bus.initiator),
      .uart_bus (uart_bus.initiator)
   );

   sram_port sram_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (sram_bus.target),
      .ram_cs_n (ram_cs_n),
      .ram_oe_n (ram_oe_n),
      .ram_we_n (ram_we_n),
      .ram_adr  (ram_adr),
      .ram_dat  (ram_dat)
   );

   uart_port #(
      .CLK_HZ (CLK_HZ),
      .BAUD   (BAUD)
   ) uart_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (uart_bus.target),
      .rxd   (rxd),
      .txd   (txd)
   );

endmodule

`default_nettype wire

/* bus_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_decode
   import sys_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         cyc,
   input  logic         stb,
   input  logic         we,
   input  addr_t        adr,
   input  data_t        dat_w,
   output data_t        dat_r,
   output logic         ack,
   sys_bus_if.initiator sram_bus,
   sys_bus_if.initiator uart_bus
);

   logic req;
   logic uart_hit;
   logic busy_q;
   logic sel_uart_q;
   logic sel_uart;

   assign req = cyc && stb;

   // UART registers shadow the SRAM in every 64K bank
   assign uart_hit = (adr[15:0] == UART_DATA_ADR) || (adr[15:0] == UART_STAT_ADR);

   // Keep the choice made when the cycle started until it is acknowledged
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy_q     <= 1'b0;
         sel_uart_q <= 1'b0;
      end
      else
      begin
         if (req && !busy_q)
         begin
            sel_uart_q <= uart_hit;
         end
         busy_q <= req && !ack;
      end
   end

   assign sel_uart = busy_q ? sel_uart_q : uart_hit;

   assign sram_bus.adr   = adr;
   assign sram_bus.dat_w = dat_w;
   assign sram_bus.we    = we;
   assign sram_bus.stb   = req && !sel_uart;

   assign uart_bus.adr   = adr;
   assign uart_bus.dat_w = dat_w;
   assign uart_bus.we    = we;
   assign uart_bus.stb   = req && sel_uart;

   // Return path from the strobed target
   assign dat_r = sel_uart ? uart_bus.dat_r : sram_bus.dat_r;
   assign ack   = sel_uart ? uart_bus.ack : sram_bus.ack;

endmodule

`default_nettype wire

/* uart_port.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_port
   import sys_pkg::*;
#(
   parameter int CLK_HZ = 50_000_000,
   parameter int BAUD   = 115_200
)
(
   input  logic      clk,
   input  logic      rst_n,
   sys_bus_if.target bus,
   input  logic      rxd,
   output logic      txd
);

   // Clocks per serial bit, and the half bit the receiver waits after the start edge
   localparam int BIT_CLKS  = CLK_HZ / BAUD;
   localparam int HALF_CLKS = BIT_CLKS / 2;
   localparam int CNT_W     = $clog2(BIT_CLKS);
   localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BIT_CLKS - 1);
   localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(HALF_CLKS - 1);

   logic             ack_q;
   data_t            dat_r_q;
   logic             access;
   logic             tx_load;
   logic             rx_read;
   logic             rx_valid;
   logic             tx_busy;
   data_t            stat_word;

   uart_tx_state_e   tx_state;
   logic [CNT_W-1:0] tx_cnt;
   logic [2:0]       tx_idx;
   uart_byte_t       tx_shift;
   logic             tx_tick;

   uart_rx_state_e   rx_state;
   logic [CNT_W-1:0] rx_cnt;
   logic [2:0]       rx_idx;
   uart_byte_t       rx_shift;
   uart_byte_t       rx_byte;
   logic             rx_meta;
   logic             rx_sync;
   logic             rx_tick;
   logic             rx_done;

   // Register access, address bit 0 picks data or status
   assign access  = bus.stb && !ack_q;
   assign tx_busy = (tx_state != TX_IDLE);
   assign tx_load = access && bus.we && !bus.adr[0] && !tx_busy;
   assign rx_read = access && !bus.we && !bus.adr[0];

   always_comb
   begin
      stat_word = '0;
      stat_word[STAT_RX_VALID_BIT] = rx_valid;
      stat_word[STAT_TX_BUSY_BIT]  = tx_busy;
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_r_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack_q    <= 1'b0;
         rx_valid <= 1'b0;
      end
      else
      begin
         ack_q <= access;
         // A new byte wins over a read in the same cycle
         if (rx_done)
         begin
            rx_valid <= 1'b1;
         end
         else if (rx_read)
         begin
            rx_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (access && !bus.we)
      begin
         dat_r_q <= bus.adr[0] ? stat_word : data_t'(rx_byte);
      end
   end

   // Transmitter
   assign tx_tick = (tx_cnt == BIT_LAST);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx_state <= TX_IDLE;
         tx_cnt   <= '0;
         tx_idx   <= '0;
         txd      <= 1'b1;
      end
      else
      begin
         if (tx_state == TX_IDLE || tx_tick)
         begin
            tx_cnt <= '0;
         end
         else
         begin
            tx_cnt <= tx_cnt + 1'b1;
         end
         case (tx_state)
            TX_IDLE:
            begin
               if (tx_load)
               begin
                  txd      <= 1'b0;
                  tx_state <= TX_START;
               end
            end
            TX_START:
            begin
               if (tx_tick)
               begin
                  txd      <= tx_shift[0];
                  tx_idx   <= '0;
                  tx_state <= TX_DATA;
               end
            end
            TX_DATA:
            begin
               if (tx_tick)
               begin
                  tx_idx <= tx_idx + 1'b1;
                  if (tx_idx == 3'd7)
                  begin
                     txd      <= 1'b1;
                     tx_state <= TX_STOP;
                  end
                  else
                  begin
                     // Next bit, the shifter moves on the same edge
                     txd <= tx_shift[1];
                  end
               end
            end
            default:
            begin
               if (tx_tick)
               begin
                  tx_state <= TX_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (tx_load)
      begin
         tx_shift <= bus.dat_w[7:0];
      end
      else if (tx_state == TX_DATA && tx_tick)
      begin
         tx_shift <= tx_shift >> 1;
      end
   end

   // Receiver, rxd is asynchronous to clk
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
      end
   end

   assign rx_tick = (rx_state == RX_START) ? (rx_cnt == HALF_LAST) : (rx_cnt == BIT_LAST);
   assign rx_done = (rx_state == RX_STOP) && rx_tick;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_idx   <= '0;
      end
      else
      begin
         if (rx_state == RX_IDLE || rx_tick)
         begin
            rx_cnt <= '0;
         end
         else
         begin
            rx_cnt <= rx_cnt + 1'b1;
         end
         case (rx_state)
            RX_IDLE:
            begin
               if (!rx_sync)
               begin
                  rx_state <= RX_START;
               end
            end
            RX_START:
            begin
               // Glitch check at the middle of the start bit
               if (rx_tick)
               begin
                  rx_idx   <= '0;
                  rx_state <= rx_sync ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA:
            begin
               if (rx_tick)
               begin
                  rx_idx <= rx_idx + 1'b1;
                  if (rx_idx == 3'd7)
                  begin
                     rx_state <= RX_STOP;
                  end
               end
            end
            default:
            begin
               if (rx_tick)
               begin
                  rx_state <= RX_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_state == RX_DATA && rx_tick)
      begin
         rx_shift <= {rx_sync, rx_shift[7:1]};
      end
      if (rx_done)
      begin
         rx_byte <= rx_shift;
      end
   end

endmodule

`default_nettype wire

/* sram_port.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_port
   import sys_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   sys_bus_if.target  bus,
   output logic       ram_cs_n,
   output logic       ram_oe_n,
   output logic       ram_we_n,
   output sram_addr_t ram_adr,
   inout  wire data_t ram_dat
);

   sram_state_e state_q;
   logic        ack_q;
   logic        drive_q;
   data_t       wr_data_q;
   data_t       rd_data_q;

   // Only one device on the bus
   assign ram_cs_n = 1'b0;

   // Write data stays on the pins through the cycle after we_n rises
   assign ram_dat = drive_q ? wr_data_q : 'z;

   assign bus.dat_r = rd_data_q;
   assign bus.ack   = ack_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q  <= SRAM_IDLE;
         ack_q    <= 1'b0;
         drive_q  <= 1'b0;
         ram_oe_n <= 1'b1;
         ram_we_n <= 1'b1;
      end
      else
      begin
         case (state_q)
            SRAM_IDLE:
            begin
               if (bus.stb)
               begin
                  ram_oe_n <= bus.we;
                  ram_we_n <= !bus.we;
                  drive_q  <= bus.we;
                  state_q  <= SRAM_ACCESS;
               end
            end
            SRAM_ACCESS:
            begin
               // End the strobe and acknowledge in the same edge
               ram_oe_n <= 1'b1;
               ram_we_n <= 1'b1;
               ack_q    <= 1'b1;
               state_q  <= SRAM_DONE;
            end
            SRAM_DONE:
            begin
               ack_q   <= 1'b0;
               drive_q <= 1'b0;
               state_q <= SRAM_IDLE;
            end
            default:
            begin
               state_q <= SRAM_IDLE;
            end
         endcase
      end
   end

   // Address, write data and read capture
   always_ff @(posedge clk)
   begin
      if (state_q == SRAM_IDLE && bus.stb)
      begin
         ram_adr   <= bus.adr[$bits(sram_addr_t)-1:0];
         wr_data_q <= bus.dat_w;
      end
      if (state_q == SRAM_ACCESS && !ram_oe_n)
      begin
         rd_data_q <= ram_dat;
      end
   end

endmodule

`default_nettype wire

/* sys_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface sys_bus_if
   import sys_pkg::*;
();

   addr_t adr;
   data_t dat_w;
   data_t dat_r;
   logic  we;
   logic  stb;
   logic  ack;

   // Decoder side
   modport initiator (
      output adr,
      output dat_w,
      output we,
      output stb,
      input  dat_r,
      input  ack
   );

   // SRAM or UART side
   modport target (
      input  adr,
      input  dat_w,
      input  we,
      input  stb,
      output dat_r,
      output ack
   );

endinterface

`default_nettype wire

/* sys_pkg.sv */
`default_nettype none

package sys_pkg;

   // Meaningful widths on the buses and pins
   typedef logic [19:0] addr_t;
   typedef logic [15:0] data_t;
   typedef logic [17:0] sram_addr_t;
   typedef logic [7:0]  uart_byte_t;

   // UART register pair, matched on the low 16 address bits only
   localparam logic [15:0] UART_DATA_ADR = 16'hFE08;
   localparam logic [15:0] UART_STAT_ADR = 16'hFE09;

   // Bit positions in the UART status word
   localparam int STAT_RX_VALID_BIT = 0;
   localparam int STAT_TX_BUSY_BIT  = 1;

   // SRAM access sequencer
   typedef enum logic [1:0] {
      SRAM_IDLE,
      SRAM_ACCESS,
      SRAM_DONE
   } sram_state_e;

   // Serial transmitter and receiver
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } uart_tx_state_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } uart_rx_state_e;

endpackage

`default_nettype wire
